// File: src.f
+incdir+verilog
verilog/cbr_pkg.sv
verilog/cbr_kernel_controller.sv
verilog/cbr_mac_array.sv
verilog/cbr_post_pipe.sv
verilog/cbr_out_fifo.sv
verilog/cbr_top.sv
testbench/tb_cbr_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_cbr_top
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the simulation log decides pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/tb_cbr_top.sv
`timescale 1ns/1ps
`include "cbr_macros.svh"

module tb_cbr_top
  import cbr_pkg::*;
();

  localparam int SEED      = 32'h59ba_bd6c;
  localparam int MAX_BEATS = 16;
  // budget for 12 tiles of under 40 cycles each plus 5 resets and the idle windows
  localparam int TIMEOUT_CYCLES = 4000;

  logic      clk;
  logic      reset;
  cbr_cfg_t  cfg;
  logic      fm_valid;
  fm_beat_t  fm_beat;
  logic      fm_ready;
  logic      credit_return = 1'b0;
  logic      out_valid;
  out_word_t out_word;

  // current tile beats
  logic signed [`CBR_ACT_W-1:0] act_mem [MAX_BEATS];
  logic signed [`CBR_WGT_W-1:0] wgt_mem [MAX_BEATS][`CBR_ROWS];

  out_word_t exp_q [$];
  string     test_name;
  int        beat_seed      = SEED;
  int        credit_seed    = SEED;
  int        expected_total = 0;
  int        rx_count       = 0;
  int        cycle_count    = 0;
  int        pending        = 0;
  int        sent_count     = 0;
  int        returned_count = 0;
  int        rx_base;
  logic      hold_credits   = 1'b0;
  cbr_cfg_t  tcfg;

  cbr_top i_dut (
    .clk(clk), .reset(reset), .cfg(cfg), .fm_valid(fm_valid), .fm_beat(fm_beat),
    .fm_ready(fm_ready), .credit_return(credit_return), .out_valid(out_valid),
    .out_word(out_word)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////
  // error exits
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    abort_run($sformatf("FAIL %s %s: expected %0h, actual %0h", test_name, what, exp_v, act_v));
  endtask

  ////////////////////
  // reference model
  // dot product, optional scale, bias, relu, shift, saturate
  function automatic out_word_t ref_result(input cbr_cfg_t c, input int row);
    longint    v;
    out_word_t w;
    v = 0;
    for (int i = 0; i < int'(c.nif_k_k); i++) begin
      v += longint'(act_mem[i]) * longint'(wgt_mem[i][row]);
    end
    if (c.mode) begin
      v = v * longint'(c.scale_e);
    end
    v = v + longint'($signed(c.bias[row]));
    if (v < 0) begin
      v = 0;
    end
    v = v >>> c.shift;
    if (v > 255) begin
      v = 255;
    end
    w.row   = 2'(row);
    w.value = 8'(v);
    return w;
  endfunction

  function automatic cbr_cfg_t make_cfg(input logic m, input int nkk, input int pof,
                                        input int sc, input int sh);
    cbr_cfg_t c;
    c              = '0;
    c.mode         = m;
    c.nif_k_k      = 16'(nkk);
    c.pof_per_core = 3'(pof);
    c.scale_e      = 16'(sc);
    c.shift        = 5'(sh);
    // one negative bias, one large
    c.bias[0]      = 16'(40);
    c.bias[1]      = 16'(-300);
    c.bias[2]      = 16'(0);
    c.bias[3]      = 16'(1000);
    return c;
  endfunction

  ////////////////////
  // stimulus helpers
  // kind 0 is random
  // kind 1 gives negative sums on rows 0-1 and huge sums on rows 2-3
  task automatic gen_tile(input int kind);
    for (int i = 0; i < MAX_BEATS; i++) begin
      act_mem[i] = (kind == 0) ? 8'($random(beat_seed)) : 8'sd127;
      for (int r = 0; r < `CBR_ROWS; r++) begin
        if (kind == 0) begin
          wgt_mem[i][r] = 8'($random(beat_seed));
        end else if (r < 2) begin
          wgt_mem[i][r] = {1'b1, 7'($random(beat_seed))};
        end else begin
          wgt_mem[i][r] = {2'b01, 6'($random(beat_seed))};
        end
      end
    end
  endtask

  // cfg is latched only in reset
  // outputs are checked in reset and right after it
  task automatic apply_reset(input cbr_cfg_t c);
    reset    = 1'b1;
    cfg      = c;
    fm_valid = 1'b0;
    repeat (5) begin
      @(negedge clk);
      assert (!out_valid) else report_mismatch("out_valid in reset", 0, 32'(out_valid));
      assert (fm_ready) else report_mismatch("fm_ready in reset", 1, 32'(fm_ready));
    end
    reset = 1'b0;
    @(negedge clk);
    assert (!out_valid) else report_mismatch("out_valid after reset", 0, 32'(out_valid));
    assert (fm_ready) else report_mismatch("fm_ready after reset", 1, 32'(fm_ready));
  endtask

  // expected words queued before the first beat
  task automatic drive_tile(input cbr_cfg_t c);
    for (int r = 0; r < int'(c.pof_per_core); r++) begin
      exp_q.push_back(ref_result(c, r));
    end
    expected_total += int'(c.pof_per_core);
    while (!fm_ready) begin
      @(negedge clk);
    end
    for (int i = 0; i < int'(c.nif_k_k); i++) begin
      fm_valid    = 1'b1;
      fm_beat.act = act_mem[i];
      for (int r = 0; r < `CBR_ROWS; r++) begin
        fm_beat.wgt[r] = wgt_mem[i][r];
      end
      @(negedge clk);
    end
    fm_valid = 1'b0;
  endtask

  // resumes on the falling edge after the last expected word
  task automatic wait_drain();
    wait (rx_count == expected_total);
    @(negedge clk);
  endtask

  ////////////////////
  // output checks on the falling edge
  always @(negedge clk) begin : compare_words
    out_word_t exp_w;
    if (out_valid) begin
      assert (exp_q.size() > 0) else abort_run("DUT sent a word that no tile produced");
      exp_w = exp_q.pop_front();
      assert (out_word == exp_w)
        else report_mismatch("out_word", 32'(exp_w), 32'(out_word));
      rx_count++;
    end
  end

  // consumer hands back one credit per received word at random times
  always @(negedge clk) begin : credit_consumer
    int coin;
    // one draw per cycle keeps the credit pattern fixed
    coin = $random(credit_seed);
    if (reset) begin
      pending        = 0;
      sent_count     = 0;
      returned_count = 0;
      credit_return  = 1'b0;
    end else begin
      credit_return = 1'b0;
      if (out_valid) begin
        sent_count++;
        pending++;
        assert (sent_count <= `CBR_FIFO_DEPTH + returned_count)
          else abort_run("DUT sent more words than it held credits for");
      end
      if (!hold_credits && pending > 0 && (coin & 1) == 1) begin
        credit_return = 1'b1;
        pending--;
        returned_count++;
      end
    end
  end

  always @(posedge clk) begin : watchdog
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      abort_run("run timed out waiting for the DUT");
    end
  end

  ////////////////////
  // test sequence
  initial begin : stimulus
    reset   = 1'b1;
    cfg     = '0;
    fm_valid = 1'b0;
    fm_beat = '0;

    test_name = "reset";
    tcfg = make_cfg(1'b1, 9, 4, 5, 9);
    apply_reset(tcfg);

    // full drain with scale
    test_name = "mode1";
    repeat (2) begin
      gen_tile(0);
      drive_tile(tcfg);
    end
    wait_drain();

    // same beats without scale
    test_name = "mode0";
    tcfg = make_cfg(1'b0, 9, 4, 5, 6);
    apply_reset(tcfg);
    drive_tile(tcfg);
    wait_drain();

    test_name = "partial";
    tcfg = make_cfg(1'b1, 12, 2, 5, 9);
    apply_reset(tcfg);
    repeat (3) begin
      gen_tile(0);
      drive_tile(tcfg);
    end
    wait_drain();
    // extras would trip compare_words here
    repeat (20) @(negedge clk);

    // 16 words against 8 credits fill the fifo
    test_name = "backpressure";
    tcfg = make_cfg(1'b1, 9, 4, 5, 9);
    apply_reset(tcfg);
    hold_credits <= 1'b1;
    rx_base = rx_count;
    repeat (4) begin
      gen_tile(0);
      drive_tile(tcfg);
    end
    repeat (40) begin
      @(negedge clk);
      assert (!fm_ready) else report_mismatch("fm_ready while stalled", 0, 32'(fm_ready));
    end
    assert (rx_count - rx_base == `CBR_FIFO_DEPTH)
      else report_mismatch("words sent on initial credits", `CBR_FIFO_DEPTH,
                           32'(rx_count - rx_base));
    hold_credits <= 1'b0;
    gen_tile(0);
    drive_tile(tcfg);
    wait_drain();

    // relu floor and 255 ceiling
    test_name = "edges";
    tcfg = make_cfg(1'b1, 9, 4, 3, 4);
    apply_reset(tcfg);
    gen_tile(1);
    drive_tile(tcfg);
    wait_drain();

    $display("all tests passed");
    $finish;
  end

endmodule

// File: verilog/cbr_top.sv
`timescale 1ns/1ps
`include "cbr_macros.svh"

module cbr_top
  import cbr_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  cbr_cfg_t  cfg,
  input  logic      fm_valid,
  input  fm_beat_t  fm_beat,
  output logic      fm_ready,
  input  logic      credit_return,
  output logic      out_valid,
  output out_word_t out_word
);

  // controller to array
  logic                   acc_en;
  logic                   acc_clear;
  logic [`CBR_ROW_W-1:0]  row_idx;
  // array to post pipe
  post_ctrl_t             post_ctrl;
  row_sum_t               row_sum;
  // post pipe to fifo
  logic                   fifo_wr;
  out_word_t              fifo_data;
  logic [`CBR_SLOT_W-1:0] free_slots;

  cbr_kernel_controller i_ctrl (
    .clk(clk), .reset(reset), .cfg(cfg), .fm_valid(fm_valid),
    .free_slots(free_slots), .fm_ready(fm_ready), .acc_en(acc_en),
    .acc_clear(acc_clear), .row_idx(row_idx), .post_ctrl(post_ctrl)
  );

  cbr_mac_array i_mac (
    .clk(clk), .reset(reset), .beat(fm_beat), .acc_en(acc_en),
    .acc_clear(acc_clear), .row_idx(row_idx), .row_sum(row_sum)
  );

  cbr_post_pipe i_post (
    .clk(clk), .reset(reset), .cfg(cfg), .post_ctrl(post_ctrl),
    .row_sum(row_sum), .fifo_wr(fifo_wr), .fifo_data(fifo_data)
  );

  cbr_out_fifo i_fifo (
    .clk(clk), .reset(reset), .wr(fifo_wr), .wr_data(fifo_data),
    .credit_return(credit_return), .free_slots(free_slots),
    .out_valid(out_valid), .out_word(out_word)
  );

endmodule

// File: verilog/cbr_out_fifo.sv
`timescale 1ns/1ps
`include "cbr_macros.svh"

module cbr_out_fifo
  import cbr_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   wr,
  input  out_word_t              wr_data,
  input  logic                   credit_return,
  output logic [`CBR_SLOT_W-1:0] free_slots,
  output logic                   out_valid,
  output out_word_t              out_word
);

  localparam int DEPTH  = `CBR_FIFO_DEPTH;
  localparam int PTR_W  = $clog2(DEPTH);
  localparam int SLOT_W = `CBR_SLOT_W;
  localparam logic [SLOT_W-1:0] FULL = SLOT_W'(DEPTH);

  out_word_t         mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [SLOT_W-1:0] count;
  // downstream buffer space we may still use
  logic [SLOT_W-1:0] credits;
  logic              push;
  logic              pop;

  assign push       = wr && (count != FULL);
  // send only with data and a credit in hand
  assign pop        = (count != '0) && (credits != '0);
  assign free_slots = FULL - count;

  ////////////////////
  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_data;
    end
    if (pop) begin
      out_word <= mem[rd_ptr];
    end
  end

  ////////////////////
  // pointers, occupancy, credits
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      credits   <= FULL;
      out_valid <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count     <= count + SLOT_W'(push) - SLOT_W'(pop);
      credits   <= credits + SLOT_W'(credit_return) - SLOT_W'(pop);
      out_valid <= pop;
    end
  end

endmodule

// File: verilog/cbr_post_pipe.sv
`timescale 1ns/1ps
`include "cbr_macros.svh"

module cbr_post_pipe
  import cbr_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  cbr_cfg_t   cfg,
  input  post_ctrl_t post_ctrl,
  input  row_sum_t   row_sum,
  output logic       fifo_wr,
  output out_word_t  fifo_data
);

  localparam int OUT_W = `CBR_OUT_W;
  // sum times zero-extended scale
  localparam int S1_W  = `CBR_ACC_W + `CBR_SCALE_W + 1;
  // one extra bit for the bias add
  localparam int S2_W  = S1_W + 1;

  // latched config
  logic [`CBR_SCALE_W-1:0]               scale_e;
  logic [`CBR_SHIFT_W-1:0]               shift;
  logic [`CBR_ROWS-1:0][`CBR_BIAS_W-1:0] bias;

  logic signed [S1_W-1:0] s1_val;
  logic [`CBR_ROW_W-1:0]  s1_row;
  logic signed [S2_W-1:0] s2_val;
  logic [`CBR_ROW_W-1:0]  s2_row;
  logic signed [S2_W-1:0] shifted;
  logic [OUT_W-1:0]       q_val;

  always_ff @(posedge clk) begin
    if (reset) begin
      scale_e <= cfg.scale_e;
      shift   <= cfg.shift;
      bias    <= cfg.bias;
    end
  end

  ////////////////////
  // stage 1, scale by E
  always_ff @(posedge clk) begin
    if (post_ctrl.mult_e_en) begin
      s1_row <= row_sum.row;
      if (post_ctrl.mult_mode) begin
        s1_val <= S1_W'(row_sum.sum) * S1_W'($signed({1'b0, scale_e}));
      end else begin
        // mode 0 skips the batch-norm scale
        s1_val <= S1_W'(row_sum.sum);
      end
    end
  end

  // stage 2, per-row bias
  always_ff @(posedge clk) begin
    if (post_ctrl.add_bias_en) begin
      s2_row <= s1_row;
      s2_val <= S2_W'(s1_val) + S2_W'($signed(bias[s1_row]));
    end
  end

  ////////////////////
  // stage 3, relu + requant, lands straight in the fifo
  always_comb begin
    shifted = s2_val >>> shift;
    if (s2_val[S2_W-1]) begin
      q_val = '0;
    end else if (|shifted[S2_W-1:OUT_W]) begin
      // saturate at 255
      q_val = '1;
    end else begin
      q_val = shifted[OUT_W-1:0];
    end
  end

  assign fifo_wr         = post_ctrl.relu_scale_en;
  assign fifo_data.row   = s2_row;
  assign fifo_data.value = q_val;

endmodule

// File: verilog/cbr_mac_array.sv
`timescale 1ns/1ps
`include "cbr_macros.svh"

module cbr_mac_array
  import cbr_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  fm_beat_t              beat,
  input  logic                  acc_en,
  input  logic                  acc_clear,
  input  logic [`CBR_ROW_W-1:0] row_idx,
  output row_sum_t              row_sum
);

  localparam int ACC_W = `CBR_ACC_W;

  // one accumulator per output channel row
  logic signed [ACC_W-1:0] acc  [`CBR_ROWS];
  logic signed [ACC_W-1:0] prod [`CBR_ROWS];

  ////////////////////
  // products, sign extended to accumulator width
  always_comb begin
    for (int r = 0; r < `CBR_ROWS; r++) begin
      prod[r] = ACC_W'($signed(beat.act)) * ACC_W'($signed(beat.wgt[r]));
    end
  end

  ////////////////////
  // accumulate
  for (genvar r = 0; r < `CBR_ROWS; r++) begin : g_row
    always_ff @(posedge clk) begin
      if (reset) begin
        acc[r] <= '0;
      end else if (acc_en) begin
        // first beat of a tile drops the old sum
        if (acc_clear) begin
          acc[r] <= prod[r];
        end else begin
          acc[r] <= acc[r] + prod[r];
        end
      end
    end
  end

  ////////////////////
  // row readout
  // selected row registered together with its index
  always_ff @(posedge clk) begin
    row_sum.row <= row_idx;
    row_sum.sum <= acc[row_idx];
  end

endmodule

// File: verilog/cbr_kernel_controller.sv
`timescale 1ns/1ps
`include "cbr_macros.svh"

module cbr_kernel_controller
  import cbr_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  cbr_cfg_t               cfg,
  input  logic                   fm_valid,
  input  logic [`CBR_SLOT_W-1:0] free_slots,
  output logic                   fm_ready,
  output logic                   acc_en,
  output logic                   acc_clear,
  output logic [`CBR_ROW_W-1:0]  row_idx,
  output post_ctrl_t             post_ctrl
);

  localparam logic [`CBR_CNT_W-1:0] CNT_ONE = 1;

  // latched config
  logic                  mode;
  logic [`CBR_CNT_W-1:0] nif_k_k;
  logic [`CBR_POF_W-1:0] pof_per_core;

  logic [`CBR_CNT_W-1:0] pixel_cnt;
  logic                  pixel_end;
  logic                  pixel_end_d;
  logic                  drain_busy;
  logic                  drain_active;
  logic                  last_row;
  logic                  pipe_busy;

  // enable chain registers
  logic                  mult_e_en;
  logic                  add_bias_en;
  logic                  relu_scale_en;
  logic                  fifo_en;
  logic                  mult_mode;

  // config only moves while reset is held
  always_ff @(posedge clk) begin
    if (reset) begin
      mode         <= cfg.mode;
      nif_k_k      <= cfg.nif_k_k;
      pof_per_core <= cfg.pof_per_core;
    end
  end

  ////////////////////
  // pixel counter

  // accumulate every beat, first beat of a tile reloads
  assign acc_en    = fm_valid;
  assign acc_clear = fm_valid && (pixel_cnt == CNT_ONE);
  // last beat of nif*k*k
  assign pixel_end = fm_valid && (pixel_cnt == nif_k_k);

  always_ff @(posedge clk) begin
    if (reset) begin
      pixel_cnt   <= CNT_ONE;
      pixel_end_d <= 1'b0;
    end else begin
      pixel_end_d <= pixel_end;
      if (pixel_end) begin
        pixel_cnt <= CNT_ONE;
      end else if (fm_valid) begin
        pixel_cnt <= pixel_cnt + 1'b1;
      end
    end
  end

  ////////////////////
  // row drain

  // delayed end opens the drain, accumulators have settled by then
  assign drain_active = pixel_end_d || drain_busy;
  assign last_row     = ({1'b0, row_idx} == pof_per_core - 1'b1);

  always_ff @(posedge clk) begin
    if (reset) begin
      drain_busy <= 1'b0;
      row_idx    <= '0;
    end else if (drain_active) begin
      if (last_row) begin
        drain_busy <= 1'b0;
        row_idx    <= '0;
      end else begin
        drain_busy <= 1'b1;
        row_idx    <= row_idx + 1'b1;
      end
    end
  end

  ////////////////////
  // enable ripple, one stage per cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      mult_e_en     <= 1'b0;
      add_bias_en   <= 1'b0;
      relu_scale_en <= 1'b0;
      fifo_en       <= 1'b0;
      mult_mode     <= 1'b0;
    end else begin
      mult_e_en     <= drain_active;
      add_bias_en   <= mult_e_en;
      relu_scale_en <= add_bias_en;
      fifo_en       <= relu_scale_en;
      // scale only in mode 1
      mult_mode     <= mode && drain_active;
    end
  end

  assign post_ctrl.sum_e_receive_en = drain_active;
  assign post_ctrl.mult_e_en        = mult_e_en;
  assign post_ctrl.add_bias_en      = add_bias_en;
  assign post_ctrl.relu_scale_en    = relu_scale_en;
  assign post_ctrl.fifo_en          = fifo_en;
  assign post_ctrl.mult_mode        = mult_mode;

  // anything still in flight through the post pipe
  assign pipe_busy = drain_active || mult_e_en || add_bias_en || relu_scale_en || fifo_en;

  // new tile only when idle and the whole drain fits in the fifo
  assign fm_ready = (pixel_cnt == CNT_ONE) && !pipe_busy &&
                    (free_slots >= {1'b0, pof_per_core});

endmodule

// File: verilog/cbr_pkg.sv
`include "cbr_macros.svh"

package cbr_pkg;

  // one feature-map beat, one weight per output row
  typedef struct packed {
    logic signed [`CBR_ACT_W-1:0]           act;
    logic [`CBR_ROWS-1:0][`CBR_WGT_W-1:0]   wgt;
  } fm_beat_t;

  // tile configuration, latched during reset
  typedef struct packed {
    logic                                   mode;
    logic [`CBR_CNT_W-1:0]                  nif_k_k;
    logic [`CBR_POF_W-1:0]                  pof_per_core;
    logic [`CBR_SCALE_W-1:0]                scale_e;
    logic [`CBR_SHIFT_W-1:0]                shift;
    logic [`CBR_ROWS-1:0][`CBR_BIAS_W-1:0]  bias;
  } cbr_cfg_t;

  // drained accumulator row
  typedef struct packed {
    logic [`CBR_ROW_W-1:0]                  row;
    logic signed [`CBR_ACC_W-1:0]           sum;
  } row_sum_t;

  // quantized result
  typedef struct packed {
    logic [`CBR_ROW_W-1:0]                  row;
    logic [`CBR_OUT_W-1:0]                  value;
  } out_word_t;

  // post pipeline enable chain
  typedef struct packed {
    logic sum_e_receive_en;
    logic mult_e_en;
    logic add_bias_en;
    logic relu_scale_en;
    logic fifo_en;
    logic mult_mode;
  } post_ctrl_t;

endpackage

// File: verilog/cbr_macros.svh
`ifndef CBR_MACROS_SVH
`define CBR_MACROS_SVH

////////////////////
// array shape
`define CBR_ROWS       4
`define CBR_ROW_W      2
`define CBR_POF_W      3

////////////////////
// data widths
`define CBR_ACT_W      8
`define CBR_WGT_W      8
`define CBR_ACC_W      24
`define CBR_OUT_W      8
`define CBR_BIAS_W     16
`define CBR_SCALE_W    16
`define CBR_SHIFT_W    5

// pixel counter, also nif*k*k
`define CBR_CNT_W      16

////////////////////
// output fifo
`define CBR_FIFO_DEPTH 8
// free slots and credits, 0..depth
`define CBR_SLOT_W     4

`endif
